// ==== hdl/mesi_cfg.svh ====
// Cluster defaults. MESI_N_SETS must be a power of two and at least 2
`ifndef MESI_CFG_SVH
`define MESI_CFG_SVH

`define MESI_ADDR_W    8    // Word address bits
`define MESI_DATA_W    32   // One word per line
`define MESI_N_SETS    4    // Direct-mapped sets per cache
`define MESI_MEM_DELAY 2    // Cycles per main memory access

`endif

// ==== hdl/coh_pkg.sv ====
// MESI line states and snoop bus commands use fixed two-bit encodings
package coh_pkg;

    // State of one cache line
    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID
    } mesi_state_t;

    typedef enum logic [1:0] {
        BUS_RD,     // Read for sharing
        BUS_RDX,    // Read for ownership
        BUS_UPGR,   // Shared to modified, no data
        BUS_WB      // Writeback of a modified line
    } bus_cmd_t;

endpackage

// ==== hdl/cache_pkg.sv ====
// Lines hold one word, and a word address splits into {tag, set index}
`include "mesi_cfg.svh"
package cache_pkg;
    import coh_pkg::*;

    localparam int SET_W = $clog2(`MESI_N_SETS);
    localparam int TAG_W = `MESI_ADDR_W - SET_W;

    typedef logic [SET_W-1:0] set_idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    typedef struct packed {
        tag_t                    tag;
        mesi_state_t             state;
        logic [`MESI_DATA_W-1:0] data;
    } line_t;

endpackage

// ==== hdl/snoop_bus_if.sv ====
// A unit holds its request until bus_ready, and snoop_valid stays high until snoop_done
`timescale 1ns/1ps
`include "mesi_cfg.svh"
interface snoop_bus_if import coh_pkg::*; ();

    // Request and response
    logic                    bus_valid;
    logic                    bus_ready;
    bus_cmd_t                bus_cmd;
    logic [`MESI_ADDR_W-1:0] bus_addr;
    logic [`MESI_DATA_W-1:0] bus_wdata;     // Only for BUS_WB
    logic                    resp_valid;
    logic [`MESI_DATA_W-1:0] resp_data;
    logic                    resp_shared;   // Other cache kept a copy

    // Snoop from the controller
    logic                    snoop_valid;
    bus_cmd_t                snoop_cmd;
    logic [`MESI_ADDR_W-1:0] snoop_addr;
    logic                    snoop_done;
    logic                    snoop_hit;
    logic                    snoop_dirty;
    logic [`MESI_DATA_W-1:0] snoop_data;

    modport unit (
        output bus_valid, bus_cmd, bus_addr, bus_wdata, snoop_done, snoop_hit,
               snoop_dirty, snoop_data,
        input  bus_ready, resp_valid, resp_data, resp_shared, snoop_valid, snoop_cmd,
               snoop_addr
    );

    modport ctrl (
        input  bus_valid, bus_cmd, bus_addr, bus_wdata, snoop_done, snoop_hit,
               snoop_dirty, snoop_data,
        output bus_ready, resp_valid, resp_data, resp_shared, snoop_valid, snoop_cmd,
               snoop_addr
    );

endinterface

// ==== hdl/cache_coh_if.sv ====
// The cache answers snoop_addr combinationally, so its unit can look up any tag
`timescale 1ns/1ps
`include "mesi_cfg.svh"
interface cache_coh_if import coh_pkg::*; ();

    logic                    miss_req;      // Held until fill_done
    logic                    miss_write;
    logic [`MESI_ADDR_W-1:0] miss_addr;
    logic                    evict_req;     // Victim is a modified line
    logic [`MESI_ADDR_W-1:0] evict_addr;
    logic [`MESI_DATA_W-1:0] evict_data;

    logic                    fill_done;     // One-cycle pulse
    logic [`MESI_DATA_W-1:0] fill_data;
    mesi_state_t             fill_state;

    logic                    snoop_req;     // Apply snoop_new_state on a hit
    logic [`MESI_ADDR_W-1:0] snoop_addr;
    mesi_state_t             snoop_new_state;
    logic                    snoop_hit;
    logic                    snoop_dirty;
    logic [`MESI_DATA_W-1:0] snoop_data;

    modport cache (
        output miss_req, miss_write, miss_addr, evict_req, evict_addr, evict_data,
               snoop_hit, snoop_dirty, snoop_data,
        input  fill_done, fill_data, fill_state, snoop_req, snoop_addr, snoop_new_state
    );

    modport coh (
        input  miss_req, miss_write, miss_addr, evict_req, evict_addr, evict_data,
               snoop_hit, snoop_dirty, snoop_data,
        output fill_done, fill_data, fill_state, snoop_req, snoop_addr, snoop_new_state
    );

endinterface

// ==== hdl/l1_dcache.sv ====
// Direct-mapped write-back cache with one request in flight and no back-pressure on rsp
`timescale 1ns/1ps
`include "mesi_cfg.svh"
module l1_dcache
    import coh_pkg::*, cache_pkg::*;
(
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  logic [`MESI_ADDR_W-1:0] req_addr,
    input  logic [`MESI_DATA_W-1:0] req_wdata,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output logic [`MESI_DATA_W-1:0] rsp_rdata,
    cache_coh_if.cache              coh
);

    line_t                   lines [`MESI_N_SETS];
    logic                    pend_q;        // Miss waiting for fill
    logic                    wr_q;
    logic                    blocked_q;
    logic [`MESI_ADDR_W-1:0] addr_q;
    logic [`MESI_DATA_W-1:0] wdata_q;
    set_idx_t                req_set, pend_set, snp_set;
    tag_t                    req_tag, pend_tag, snp_tag;
    line_t                   req_line, pend_line, snp_line;
    logic                    req_hit, req_acc;

    assign req_set   = req_addr[SET_W-1:0];
    assign req_tag   = req_addr[`MESI_ADDR_W-1:SET_W];
    assign pend_set  = addr_q[SET_W-1:0];
    assign pend_tag  = addr_q[`MESI_ADDR_W-1:SET_W];
    assign snp_set   = coh.snoop_addr[SET_W-1:0];
    assign snp_tag   = coh.snoop_addr[`MESI_ADDR_W-1:SET_W];
    assign req_line  = lines[req_set];
    assign pend_line = lines[pend_set];
    assign snp_line  = lines[snp_set];

    // Writes need ownership, reads any valid copy
    assign req_hit = req_line.state != INVALID && req_line.tag == req_tag &&
                     (!req_write || req_line.state inside {MODIFIED, EXCLUSIVE});
    assign req_ready = !pend_q && !blocked_q && !coh.snoop_req;
    assign req_acc   = req_valid && req_ready;

    assign coh.miss_req   = pend_q;
    assign coh.miss_write = wr_q;
    assign coh.miss_addr  = addr_q;
    assign coh.evict_req  = pend_q && pend_line.state == MODIFIED && pend_line.tag != pend_tag;
    assign coh.evict_addr = {pend_line.tag, pend_set};
    assign coh.evict_data = pend_line.data;

    assign coh.snoop_hit   = snp_line.state != INVALID && snp_line.tag == snp_tag;
    assign coh.snoop_dirty = coh.snoop_hit && snp_line.state == MODIFIED;
    assign coh.snoop_data  = snp_line.data;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `MESI_N_SETS; i++) begin
                lines[i] <= '{tag: '0, state: INVALID, data: '0};
            end
            pend_q    <= 1'b0;
            blocked_q <= 1'b1;              // Not ready in the first cycle
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            blocked_q <= coh.snoop_req;     // Idle one cycle after a snoop update
            if (coh.snoop_req && coh.snoop_hit) begin
                lines[snp_set].state <= coh.snoop_new_state;
            end
            if (req_acc && req_hit) begin
                rsp_valid <= 1'b1;
                if (req_write) begin
                    lines[req_set].data  <= req_wdata;
                    lines[req_set].state <= MODIFIED;   // E goes silently to M
                end
            end else if (req_acc) begin
                pend_q <= 1'b1;
            end
            if (coh.fill_done) begin
                lines[pend_set] <= '{tag: pend_tag, state: coh.fill_state,
                                     data: wr_q ? wdata_q : coh.fill_data};
                pend_q    <= 1'b0;
                rsp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (req_acc) begin
            addr_q  <= req_addr;
            wr_q    <= req_write;
            wdata_q <= req_wdata;
        end
        if (req_acc && req_hit) begin
            rsp_rdata <= req_write ? req_wdata : req_line.data;
        end else if (coh.fill_done) begin
            rsp_rdata <= wr_q ? wdata_q : coh.fill_data;
        end
    end

    // Every response belongs to a hit accepted last cycle or to a filled miss
    a_rsp_has_req: assert property (@(posedge CLK) disable iff (!nRST)
        rsp_valid |-> $past(req_valid && req_ready) || $past(pend_q));

endmodule

// ==== hdl/coherency_unit.sv ====
// One bus transaction at a time per unit, and a snoop preempts a request not yet granted
`timescale 1ns/1ps
`include "mesi_cfg.svh"
module coherency_unit
    import coh_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    cache_coh_if.coh   cache,
    snoop_bus_if.unit  bus
);

    typedef enum logic [2:0] {
        IDLE, WRITEBACK, READ_REQ, WRITE_REQ, RESP_CHKTAG, RESP_SEND
    } state_t;

    state_t                  state, next_state;
    logic                    issued_q;      // Granted, waiting for resp_valid
    logic                    upgr_q;        // Write miss on a shared copy
    logic                    req_state;
    logic [`MESI_DATA_W-1:0] sdata_q;

    assign req_state = state inside {WRITEBACK, READ_REQ, WRITE_REQ};

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (bus.snoop_valid)
                    next_state = RESP_CHKTAG;
                else if (cache.evict_req)
                    next_state = WRITEBACK;
                else if (cache.miss_req)
                    next_state = cache.miss_write ? WRITE_REQ : READ_REQ;
            end
            WRITEBACK, READ_REQ, WRITE_REQ: begin
                if (!issued_q && bus.snoop_valid)
                    next_state = RESP_CHKTAG;
                else if (issued_q && bus.resp_valid)
                    next_state = IDLE;
            end
            RESP_CHKTAG: next_state = cache.snoop_dirty ? RESP_SEND : IDLE;
            RESP_SEND:   next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            issued_q <= 1'b0;
            upgr_q   <= 1'b0;
        end else begin
            state <= next_state;
            if (bus.bus_valid && bus.bus_ready)
                issued_q <= 1'b1;
            else if (bus.resp_valid)
                issued_q <= 1'b0;
            if (state == IDLE && next_state == WRITE_REQ)
                upgr_q <= cache.snoop_hit;  // Lookup is on miss_addr in IDLE
        end
    end

    always_ff @(posedge CLK) begin
        if (state == RESP_CHKTAG)
            sdata_q <= cache.snoop_data;
    end

    always_comb begin
        if (state == WRITEBACK)
            bus.bus_cmd = BUS_WB;
        else if (state == READ_REQ)
            bus.bus_cmd = BUS_RD;
        else if (upgr_q)
            bus.bus_cmd = BUS_UPGR;
        else
            bus.bus_cmd = BUS_RDX;

        if (state == WRITE_REQ)
            cache.fill_state = MODIFIED;
        else if (bus.resp_shared)
            cache.fill_state = SHARED;
        else
            cache.fill_state = EXCLUSIVE;

        // Remote reads share the line, anything else takes it away
        if (state == RESP_CHKTAG && bus.snoop_cmd == BUS_RD)
            cache.snoop_new_state = SHARED;
        else
            cache.snoop_new_state = INVALID;
    end

    assign bus.bus_valid  = req_state && !issued_q;
    assign bus.bus_addr   = (state == WRITEBACK) ? cache.evict_addr : cache.miss_addr;
    assign bus.bus_wdata  = cache.evict_data;

    assign bus.snoop_done  = (state == RESP_CHKTAG && !cache.snoop_dirty) || state == RESP_SEND;
    assign bus.snoop_hit   = state == RESP_SEND || (state == RESP_CHKTAG && cache.snoop_hit);
    assign bus.snoop_dirty = state == RESP_SEND;
    assign bus.snoop_data  = sdata_q;

    assign cache.fill_done = issued_q && bus.resp_valid && state != WRITEBACK;
    assign cache.fill_data = bus.resp_data;

    // Written-back victim is dropped once memory has it
    assign cache.snoop_req  = state == RESP_CHKTAG ||
                              (state == WRITEBACK && issued_q && bus.resp_valid);
    assign cache.snoop_addr = (state == RESP_CHKTAG) ? bus.snoop_addr :
                              (state == WRITEBACK)   ? cache.evict_addr : cache.miss_addr;

    a_done_in_snoop: assert property (@(posedge CLK) disable iff (!nRST)
        bus.snoop_done |-> bus.snoop_valid);

endmodule

// ==== hdl/snoop_bus_ctrl.sv ====
// Two units only, and memory is word-addressed, zeroed at reset and read after MESI_MEM_DELAY
`timescale 1ns/1ps
`include "mesi_cfg.svh"
module snoop_bus_ctrl
    import coh_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    snoop_bus_if.ctrl  unit0,
    snoop_bus_if.ctrl  unit1
);

    localparam int CNT_W = $clog2(`MESI_MEM_DELAY + 1);

    typedef enum logic [1:0] {C_IDLE, C_SNOOP, C_MEM} ctrl_state_t;

    ctrl_state_t             state;
    logic [`MESI_DATA_W-1:0] mem [2**`MESI_ADDR_W];
    logic [1:0]              valid, gnt;
    logic                    win, prio_q, owner_q;
    logic                    shared_q, dirty_q, done, last;
    bus_cmd_t                win_cmd, cmd_q;
    logic [`MESI_ADDR_W-1:0] addr_q;
    logic [`MESI_DATA_W-1:0] wdata_q, sdata_q, rdata;
    logic [CNT_W-1:0]        cnt_q;

    assign valid   = {unit1.bus_valid, unit0.bus_valid};
    assign win     = (&valid) ? prio_q : valid[1];  // Round-robin on conflict
    assign win_cmd = win ? unit1.bus_cmd : unit0.bus_cmd;
    assign gnt[0]  = state == C_IDLE && valid[0] && !win;
    assign gnt[1]  = state == C_IDLE && valid[1] && win;

    // Snoop answer comes from the unit that did not win
    assign done  = owner_q ? unit0.snoop_done : unit1.snoop_done;
    assign last  = state == C_MEM && cnt_q == CNT_W'(`MESI_MEM_DELAY - 1);
    assign rdata = dirty_q ? sdata_q : mem[addr_q];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= C_IDLE;
            prio_q   <= 1'b0;
            owner_q  <= 1'b0;
            shared_q <= 1'b0;
            dirty_q  <= 1'b0;
            cnt_q    <= '0;
            for (int i = 0; i < 2**`MESI_ADDR_W; i++) begin
                mem[i] <= '0;
            end
        end else begin
            unique case (state)
                C_IDLE: begin
                    if (|valid) begin
                        owner_q  <= win;
                        prio_q   <= !win;
                        shared_q <= 1'b0;
                        dirty_q  <= 1'b0;
                        cnt_q    <= '0;
                        state    <= (win_cmd == BUS_WB) ? C_MEM : C_SNOOP;
                    end
                end
                C_SNOOP: begin
                    if (done) begin
                        shared_q <= owner_q ? unit0.snoop_hit : unit1.snoop_hit;
                        dirty_q  <= owner_q ? unit0.snoop_dirty : unit1.snoop_dirty;
                        state    <= C_MEM;
                    end
                end
                C_MEM: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last) begin
                        state <= C_IDLE;
                        if (cmd_q == BUS_WB)
                            mem[addr_q] <= wdata_q;
                        else if (dirty_q)
                            mem[addr_q] <= sdata_q;     // Supplied data updates memory
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (|gnt) begin
            cmd_q   <= win_cmd;
            addr_q  <= win ? unit1.bus_addr : unit0.bus_addr;
            wdata_q <= win ? unit1.bus_wdata : unit0.bus_wdata;
        end
        if (state == C_SNOOP && done)
            sdata_q <= owner_q ? unit0.snoop_data : unit1.snoop_data;
    end

    assign unit0.bus_ready   = gnt[0];
    assign unit0.snoop_valid = state == C_SNOOP && owner_q;
    assign unit0.snoop_cmd   = cmd_q;
    assign unit0.snoop_addr  = addr_q;
    assign unit0.resp_valid  = last && !owner_q;
    assign unit0.resp_data   = rdata;
    assign unit0.resp_shared = shared_q;

    assign unit1.bus_ready   = gnt[1];
    assign unit1.snoop_valid = state == C_SNOOP && !owner_q;
    assign unit1.snoop_cmd   = cmd_q;
    assign unit1.snoop_addr  = addr_q;
    assign unit1.resp_valid  = last && owner_q;
    assign unit1.resp_data   = rdata;
    assign unit1.resp_shared = shared_q;

    // Bus owner raises no second request while its transaction is in flight
    a_owner_quiet: assert property (@(posedge CLK) disable iff (!nRST)
        state != C_IDLE |-> !(owner_q ? unit1.bus_valid : unit0.bus_valid));

endmodule

// ==== hdl/mesi_cluster.sv ====
// Two CPUs, each with one outstanding request and a response that cannot be stalled
`timescale 1ns/1ps
`include "mesi_cfg.svh"
module mesi_cluster (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    req_valid [2],
    output logic                    req_ready [2],
    input  logic                    req_write [2],
    input  logic [`MESI_ADDR_W-1:0] req_addr  [2],
    input  logic [`MESI_DATA_W-1:0] req_wdata [2],
    output logic                    rsp_valid [2],
    output logic [`MESI_DATA_W-1:0] rsp_rdata [2]
);

    cache_coh_if cc_if [2] ();
    snoop_bus_if sb_if [2] ();

    for (genvar i = 0; i < 2; i++) begin : g_cpu
        l1_dcache dcache_inst (
            .CLK       (CLK),
            .nRST      (nRST),
            .req_valid (req_valid[i]),
            .req_write (req_write[i]),
            .req_addr  (req_addr[i]),
            .req_wdata (req_wdata[i]),
            .req_ready (req_ready[i]),
            .rsp_valid (rsp_valid[i]),
            .rsp_rdata (rsp_rdata[i]),
            .coh       (cc_if[i])
        );

        coherency_unit coh_inst (
            .CLK   (CLK),
            .nRST  (nRST),
            .cache (cc_if[i]),
            .bus   (sb_if[i])
        );
    end

    snoop_bus_ctrl bus_ctrl_inst (
        .CLK   (CLK),
        .nRST  (nRST),
        .unit0 (sb_if[0]),
        .unit1 (sb_if[1])
    );

endmodule

// ==== verif/mesi_cluster_tb.sv ====
// Needs hdl/ on the include path, and each CPU has at most one request in flight at a time
`timescale 1ns/1ps
`include "mesi_cfg.svh"
module mesi_cluster_tb;

    localparam int N_REQ = 4 + 3 + 4 + 3 + 4 + 200;                 // Requests over all tests
    localparam int LIMIT = 20 * N_REQ * (2 * `MESI_MEM_DELAY + 6);   // Cycle budget

    logic                    CLK;
    logic                    nRST;
    logic                    req_valid [2];
    logic                    req_ready [2];
    logic                    req_write [2];
    logic [`MESI_ADDR_W-1:0] req_addr  [2];
    logic [`MESI_DATA_W-1:0] req_wdata [2];
    logic                    rsp_valid [2];
    logic [`MESI_DATA_W-1:0] rsp_rdata [2];

    logic [`MESI_DATA_W-1:0] ref_mem  [2**`MESI_ADDR_W];  // Last value written per address
    logic [`MESI_DATA_W-1:0] exp_data [2];
    logic                    is_read  [2];
    logic                    busy     [2];                // Request outstanding on that CPU
    string                   test_name;
    integer                  seed;
    int                      cycle_cnt = 0;

    mesi_cluster mesi_cluster_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    // Drives one request on the falling edge, then waits for its response
    task automatic run_access(input int cpu, input bit write,
                              input logic [`MESI_ADDR_W-1:0] addr,
                              input logic [`MESI_DATA_W-1:0] data);
        @(negedge CLK);
        if (write)
            ref_mem[addr] = data;
        else
            exp_data[cpu] = ref_mem[addr];
        is_read[cpu]   = !write;
        busy[cpu]      = 1'b1;
        req_valid[cpu] = 1'b1;
        req_write[cpu] = write;
        req_addr[cpu]  = addr;
        req_wdata[cpu] = data;
        while (!req_ready[cpu])
            @(negedge CLK);
        @(negedge CLK);                         // Accepted on the rising edge just passed
        req_valid[cpu] = 1'b0;
        while (!rsp_valid[cpu])
            @(negedge CLK);
        @(negedge CLK);                         // Let the checkers sample the response
        busy[cpu] = 1'b0;
    endtask

    for (genvar i = 0; i < 2; i++) begin : g_check
        a_read_data: assert property (@(posedge CLK) disable iff (!nRST)
            rsp_valid[i] && is_read[i] |-> rsp_rdata[i] == exp_data[i])
        else begin
            $display("ERROR: %s cpu%0d expected %h actual %h",
                     test_name, i, exp_data[i], rsp_rdata[i]);
            stop_with_failure();
        end

        a_rsp_outstanding: assert property (@(posedge CLK) disable iff (!nRST)
            rsp_valid[i] |-> busy[i])
        else begin
            $display("CPU %0d gave a response with no request outstanding in %s", i, test_name);
            stop_with_failure();
        end

        // Accepted and still waiting for its response
        a_ready_in_flight: assert property (@(posedge CLK) disable iff (!nRST)
            busy[i] && !req_valid[i] && !rsp_valid[i] |-> !req_ready[i])
        else begin
            $display("CPU %0d was ready with a request in flight in %s", i, test_name);
            stop_with_failure();
        end
    end

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("Timeout reached after %0d cycles in %s", cycle_cnt, test_name);
            stop_with_failure();
        end
    end

    initial begin
        int                      cpu;
        bit                      wr;
        logic [`MESI_ADDR_W-1:0] addr;
        logic [`MESI_DATA_W-1:0] data;

        seed      = 32'h4dcc;
        test_name = "reset";
        nRST      = 1'b0;
        for (int i = 0; i < 2; i++) begin
            req_valid[i] = 1'b0;
            req_write[i] = 1'b0;
            req_addr[i]  = '0;
            req_wdata[i] = '0;
            exp_data[i]  = '0;
            is_read[i]   = 1'b0;
            busy[i]      = 1'b0;
        end
        for (int a = 0; a < 2**`MESI_ADDR_W; a++)
            ref_mem[a] = '0;                    // Memory is zero after reset
        repeat (4) @(negedge CLK);
        nRST = 1'b1;

        test_name = "cold_read";
        run_access(0, 0, 8'h01, '0);
        run_access(1, 0, 8'h02, '0);
        run_access(0, 0, 8'h01, '0);            // Second read hits in E
        run_access(1, 0, 8'h02, '0);

        test_name = "remote_dirty";
        run_access(0, 1, 8'h05, 32'hcafe_0005);
        run_access(1, 0, 8'h05, '0);            // Supplied from CPU0's M line
        run_access(0, 0, 8'h05, '0);

        test_name = "upgrade_invalidate";
        run_access(0, 0, 8'h0a, '0);
        run_access(1, 0, 8'h0a, '0);
        run_access(1, 1, 8'h0a, 32'h1234_abcd); // S to M by upgrade
        run_access(0, 0, 8'h0a, '0);

        test_name = "eviction_writeback";
        run_access(0, 1, 8'h14, 32'haaaa_0014);
        run_access(0, 1, 8'h24, 32'hbbbb_0024); // Same set, other tag
        run_access(1, 0, 8'h14, '0);

        test_name = "concurrent";
        fork
            run_access(0, 1, 8'h31, 32'h0000_3131);
            run_access(1, 1, 8'h42, 32'h0000_4242);
        join
        fork
            run_access(0, 0, 8'h42, '0);
            run_access(1, 0, 8'h31, '0);
        join

        test_name = "random";
        for (int n = 0; n < 200; n++) begin
            cpu  = $random(seed) & 1;
            wr   = $random(seed) & 1;
            addr = 8'h80 + ($random(seed) & 15);  // 16 addresses over all sets
            data = $random(seed);
            run_access(cpu, wr, addr, data);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== mesi_cluster.f ====
+incdir+hdl
hdl/coh_pkg.sv
hdl/cache_pkg.sv
hdl/snoop_bus_if.sv
hdl/cache_coh_if.sv
hdl/l1_dcache.sv
hdl/coherency_unit.sv
hdl/snoop_bus_ctrl.sv
hdl/mesi_cluster.sv
verif/mesi_cluster_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Wno-fatal
TOP       = mesi_cluster_tb
FILELIST  = mesi_cluster.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
